//--- udp_loopback_settings.svh
// Loopback port, local IP, reply TTL, buffer depth and beat width macros
`ifndef UDP_LOOPBACK_SETTINGS_SVH
`define UDP_LOOPBACK_SETTINGS_SVH

// UDP port answered by the loopback path
`define LOOP_UDP_PORT 16'd1234

// Source address of every reply, 22.1.212.10
`define LOCAL_IP 32'h1601_d40a

// TTL written into replies
`define REPLY_TTL 8'd64

// Payload buffer depth in beats, power of two
`define FIFO_DEPTH 16

// Bytes per payload beat
`define BEAT_BYTES 8

`endif

//--- udp_loopback_pkg.sv
// Vector typedefs, header and beat structs, filter state enum for the UDP loopback
`include "udp_loopback_settings.svh"

package udp_loopback_pkg;

  // Payload beat and its byte enables
  typedef logic [`BEAT_BYTES*8-1:0] data_t;
  typedef logic [`BEAT_BYTES-1:0]   keep_t;

  typedef logic [15:0] port_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [7:0]  ttl_t;
  typedef logic [15:0] udp_len_t;

  // Header fields that the loopback path reads or rewrites
  typedef struct packed {
    ip_addr_t source_ip;
    ip_addr_t dest_ip;
    port_t    source_port;
    port_t    dest_port;
    udp_len_t length;
    ttl_t     ttl;
  } udp_hdr_t;

  typedef struct packed {
    data_t data;
    keep_t keep;
    logic  last;
  } beat_t;

  typedef enum logic [1:0] {
    flt_idle,
    flt_pass,
    flt_drop
  } filter_state_t;

endpackage

//--- udp_port_filter.sv
// Per-frame destination port filter feeding the reply builder and payload buffer
`timescale 1ns/1ps
`include "udp_loopback_settings.svh"

module udp_port_filter (
  input  logic                       clk,
  input  logic                       rst,
  input  udp_loopback_pkg::udp_hdr_t rx_hdr,
  input  logic                       rx_hdr_valid,
  output logic                       rx_hdr_ready,
  input  udp_loopback_pkg::beat_t    rx_beat,
  input  logic                       rx_beat_valid,
  output logic                       rx_beat_ready,
  output udp_loopback_pkg::udp_hdr_t req_hdr,
  output logic                       req_valid,
  input  logic                       req_ready,
  output udp_loopback_pkg::beat_t    fifo_in,
  output logic                       fifo_in_valid,
  input  logic                       fifo_in_ready
);
  import udp_loopback_pkg::*;

  filter_state_t state;
  filter_state_t state_next;
  logic          hdr_fire;
  logic          beat_fire;
  logic          port_match;

  // New header only between frames and with a free reply slot
  assign rx_hdr_ready = (state == flt_idle) && req_ready;
  assign hdr_fire     = rx_hdr_valid && rx_hdr_ready;
  assign port_match   = (rx_hdr.dest_port == `LOOP_UDP_PORT);

  assign rx_beat_ready = (state == flt_pass) ? fifo_in_ready : (state == flt_drop);
  assign beat_fire     = rx_beat_valid && rx_beat_ready;

  assign fifo_in       = rx_beat;
  assign fifo_in_valid = rx_beat_valid && (state == flt_pass);

  always_comb begin
    state_next = state;
    case (state)
      flt_idle: begin
        if (hdr_fire) begin
          state_next = port_match ? flt_pass : flt_drop;
        end
      end
      flt_pass, flt_drop: begin
        if (beat_fire && rx_beat.last) begin
          state_next = flt_idle;
        end
      end
      default: state_next = flt_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= flt_idle;
      req_valid <= 1'b0;
    end else begin
      state <= state_next;
      if (hdr_fire && port_match) begin
        req_valid <= 1'b1;
      end else if (req_ready) begin
        req_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_fire) begin
      req_hdr <= rx_hdr;
    end
  end

  // Payload never moves outside a frame
  assert property (@(posedge clk) disable iff (rst)
    state == flt_idle |-> !beat_fire);

  // Slot was free at header time, so the request leaves right away
  assert property (@(posedge clk) disable iff (rst)
    req_valid |-> req_ready);

endmodule

//--- udp_reply_header.sv
// One-entry holding stage that turns a request header into the reply header
`timescale 1ns/1ps
`include "udp_loopback_settings.svh"

module udp_reply_header (
  input  logic                       clk,
  input  logic                       rst,
  input  udp_loopback_pkg::udp_hdr_t req_hdr,
  input  logic                       req_valid,
  output logic                       req_ready,
  output udp_loopback_pkg::udp_hdr_t tx_hdr,
  output logic                       tx_hdr_valid,
  input  logic                       tx_hdr_ready
);
  import udp_loopback_pkg::*;

  udp_hdr_t reply;
  logic     full;
  logic     req_fire;

  assign req_ready    = !full;
  assign req_fire     = req_valid && req_ready;
  assign tx_hdr_valid = full;

  // Swap ports, answer to the sender from the local address
  always_comb begin
    reply.source_ip   = `LOCAL_IP;
    reply.dest_ip     = req_hdr.source_ip;
    reply.source_port = req_hdr.dest_port;
    reply.dest_port   = req_hdr.source_port;
    reply.length      = req_hdr.length;
    reply.ttl         = `REPLY_TTL;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (req_fire) begin
      full <= 1'b1;
    end else if (tx_hdr_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      tx_hdr <= reply;
    end
  end

  // Header held steady while the sink stalls
  assert property (@(posedge clk) disable iff (rst)
    tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr));

endmodule

//--- payload_fifo.sv
// Circular payload beat buffer with a registered output stage
`timescale 1ns/1ps
`include "udp_loopback_settings.svh"

module payload_fifo #(
  parameter int DEPTH = `FIFO_DEPTH
) (
  input  logic                    clk,
  input  logic                    rst,
  input  udp_loopback_pkg::beat_t in_beat,
  input  logic                    in_valid,
  output logic                    in_ready,
  output udp_loopback_pkg::beat_t out_beat,
  output logic                    out_valid,
  input  logic                    out_ready
);
  import udp_loopback_pkg::*;

  localparam int ADDR_W = $clog2(DEPTH);

  beat_t             mem [DEPTH];
  logic [ADDR_W:0]   wr_ptr;
  logic [ADDR_W:0]   rd_ptr;
  logic [ADDR_W:0]   fill;
  logic              mem_empty;
  logic              mem_full;
  logic              wr_fire;
  logic              out_load;
  logic              bypass;
  logic              mem_write;
  logic              mem_read;

  assign fill      = wr_ptr - rd_ptr;
  assign mem_empty = (fill == '0);
  assign mem_full  = (fill == (ADDR_W+1)'(DEPTH));

  assign in_ready = !mem_full;
  assign wr_fire  = in_valid && in_ready;

  // Output register can take a beat this cycle
  assign out_load = !out_valid || out_ready;

  // Straight into the output register when nothing older is waiting
  assign bypass    = wr_fire && mem_empty && out_load;
  assign mem_write = wr_fire && !bypass;
  assign mem_read  = out_load && !mem_empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      out_valid <= 1'b0;
    end else begin
      if (mem_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (mem_read) begin
        rd_ptr    <= rd_ptr + 1'b1;
        out_valid <= 1'b1;
      end else if (bypass) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_write) begin
      mem[wr_ptr[ADDR_W-1:0]] <= in_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_read) begin
      out_beat <= mem[rd_ptr[ADDR_W-1:0]];
    end else if (bypass) begin
      out_beat <= in_beat;
    end
  end

  // Occupancy never passes the storage size
  assert property (@(posedge clk) disable iff (rst)
    fill <= (ADDR_W+1)'(DEPTH));

  // Output only turns valid from a beat that really arrived
  assert property (@(posedge clk) disable iff (rst)
    $rose(out_valid) |-> $past(wr_fire) || !$past(mem_empty));

endmodule

//--- led_first_byte.sv
// LED capture of the low byte of each transmitted frame's first payload beat
`timescale 1ns/1ps

module led_first_byte (
  input  logic                    clk,
  input  logic                    rst,
  input  udp_loopback_pkg::beat_t beat,
  input  logic                    valid,
  input  logic                    ready,
  output logic [7:0]              led
);

  logic fire;
  logic first;

  assign fire = valid && ready;

  // Next transfer opens a frame
  always_ff @(posedge clk) begin
    if (rst) begin
      first <= 1'b1;
    end else if (fire) begin
      first <= beat.last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      led <= 8'd0;
    end else if (fire && first) begin
      led <= beat.data[7:0];
    end
  end

endmodule

//--- udp_loopback_top.sv
// UDP loopback top level with filter, reply header, payload buffer and LED capture
`timescale 1ns/1ps

module udp_loopback_top (
  input  logic                       clk,
  input  logic                       rst,
  input  udp_loopback_pkg::udp_hdr_t rx_hdr,
  input  logic                       rx_hdr_valid,
  output logic                       rx_hdr_ready,
  input  udp_loopback_pkg::beat_t    rx_beat,
  input  logic                       rx_beat_valid,
  output logic                       rx_beat_ready,
  output udp_loopback_pkg::udp_hdr_t tx_hdr,
  output logic                       tx_hdr_valid,
  input  logic                       tx_hdr_ready,
  output udp_loopback_pkg::beat_t    tx_beat,
  output logic                       tx_beat_valid,
  input  logic                       tx_beat_ready,
  output logic [7:0]                 led
);
  import udp_loopback_pkg::*;

  // Filter to reply builder
  udp_hdr_t req_hdr;
  logic     req_valid;
  logic     req_ready;

  // Filter to payload buffer
  beat_t    fifo_in;
  logic     fifo_in_valid;
  logic     fifo_in_ready;

  udp_port_filter u_port_filter (
    .clk           (clk),
    .rst           (rst),
    .rx_hdr        (rx_hdr),
    .rx_hdr_valid  (rx_hdr_valid),
    .rx_hdr_ready  (rx_hdr_ready),
    .rx_beat       (rx_beat),
    .rx_beat_valid (rx_beat_valid),
    .rx_beat_ready (rx_beat_ready),
    .req_hdr       (req_hdr),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .fifo_in       (fifo_in),
    .fifo_in_valid (fifo_in_valid),
    .fifo_in_ready (fifo_in_ready)
  );

  udp_reply_header u_reply_header (
    .clk          (clk),
    .rst          (rst),
    .req_hdr      (req_hdr),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .tx_hdr       (tx_hdr),
    .tx_hdr_valid (tx_hdr_valid),
    .tx_hdr_ready (tx_hdr_ready)
  );

  payload_fifo u_payload_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_beat   (fifo_in),
    .in_valid  (fifo_in_valid),
    .in_ready  (fifo_in_ready),
    .out_beat  (tx_beat),
    .out_valid (tx_beat_valid),
    .out_ready (tx_beat_ready)
  );

  // Watches the transmit payload port only
  led_first_byte u_led_first_byte (
    .clk   (clk),
    .rst   (rst),
    .beat  (tx_beat),
    .valid (tx_beat_valid),
    .ready (tx_beat_ready),
    .led   (led)
  );

endmodule

//--- tb_udp_loopback.sv
// Directed testbench for the UDP loopback top level with drive, compare and watchdog
`timescale 1ns/1ps
`include "udp_loopback_settings.svh"

module tb_udp_loopback;
  import udp_loopback_pkg::*;

  // Beats sent by all tests together: 5 + 7 + 42 + 6
  localparam int TOTAL_BEATS = 60;
  localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + 200;

  logic       clk;
  logic       rst;
  udp_hdr_t   rx_hdr;
  logic       rx_hdr_valid;
  logic       rx_hdr_ready;
  beat_t      rx_beat;
  logic       rx_beat_valid;
  logic       rx_beat_ready;
  udp_hdr_t   tx_hdr;
  logic       tx_hdr_valid;
  logic       tx_hdr_ready;
  beat_t      tx_beat;
  logic       tx_beat_valid;
  logic       tx_beat_ready;
  logic [7:0] led;

  udp_hdr_t   exp_hdr_q[$];
  beat_t      exp_beat_q[$];
  beat_t      mon_beat;
  logic [7:0] frame_led;
  logic       tx_first = 1'b1;
  logic       led_due = 1'b0;
  logic       stall_en = 1'b0;
  int         cycles = 0;
  int         errors = 0;
  int         tests_run = 0;
  int         tests_failed = 0;
  int         errors_at_start;
  int         tx_hdr_count = 0;
  int         tx_beat_count = 0;
  string      test_name = "reset";

  udp_loopback_top u_udp_loopback_top (
    .clk           (clk),
    .rst           (rst),
    .rx_hdr        (rx_hdr),
    .rx_hdr_valid  (rx_hdr_valid),
    .rx_hdr_ready  (rx_hdr_ready),
    .rx_beat       (rx_beat),
    .rx_beat_valid (rx_beat_valid),
    .rx_beat_ready (rx_beat_ready),
    .tx_hdr        (tx_hdr),
    .tx_hdr_valid  (tx_hdr_valid),
    .tx_hdr_ready  (tx_hdr_ready),
    .tx_beat       (tx_beat),
    .tx_beat_valid (tx_beat_valid),
    .tx_beat_ready (tx_beat_ready),
    .led           (led)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: run passed %0d cycles in test %s", CYCLE_LIMIT, test_name);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // Sink side ready, random under stall
  always @(posedge clk) begin
    #1;
    if (stall_en) begin
      tx_hdr_ready  = ($urandom_range(1) == 0);
      tx_beat_ready = ($urandom_range(1) == 0);
    end else begin
      tx_hdr_ready  = 1'b1;
      tx_beat_ready = 1'b1;
    end
  end

  task automatic note_failure(input string what);
    $display("%s: %s", test_name, what);
    errors++;
  endtask

  task automatic check_hdr(input udp_hdr_t exp, input udp_hdr_t act);
    if (act !== exp) begin
      $display("ERR %s header expected %h actual %h", test_name, exp, act);
      errors++;
    end
  endtask

  task automatic check_beat(input beat_t exp, input beat_t act);
    if (act !== exp) begin
      $display("ERR %s beat expected %h actual %h", test_name, exp, act);
      errors++;
    end
  endtask

  task automatic check_led(input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("ERR %s led expected %h actual %h", test_name, exp, act);
      errors++;
    end
  endtask

  // Transfers seen at the falling edge complete on the next rising edge
  always @(negedge clk) begin
    if (!rst) begin
      if (led_due) begin
        check_led(frame_led, led);
        led_due = 1'b0;
      end
      if (tx_hdr_valid && tx_hdr_ready) begin
        tx_hdr_count++;
        if (exp_hdr_q.size() == 0) begin
          note_failure("reply header appeared on tx with none expected");
        end else begin
          check_hdr(exp_hdr_q.pop_front(), tx_hdr);
        end
      end
      if (tx_beat_valid && tx_beat_ready) begin
        tx_beat_count++;
        if (exp_beat_q.size() == 0) begin
          note_failure("payload beat appeared on tx with none expected");
        end else begin
          mon_beat = exp_beat_q.pop_front();
          if (tx_first) begin
            frame_led = mon_beat.data[7:0];
          end
          tx_first = mon_beat.last;
          led_due  = mon_beat.last;
          check_beat(mon_beat, tx_beat);
        end
      end
    end
  end

  function automatic udp_hdr_t expected_reply(input udp_hdr_t req);
    udp_hdr_t r;
    r.source_ip   = `LOCAL_IP;
    r.dest_ip     = req.source_ip;
    r.source_port = req.dest_port;
    r.dest_port   = req.source_port;
    r.length      = req.length;
    r.ttl         = `REPLY_TTL;
    return r;
  endfunction

  function automatic udp_hdr_t make_hdr(input port_t dport, input int nbeats);
    udp_hdr_t h;
    h.source_ip   = $urandom;
    h.dest_ip     = `LOCAL_IP;
    h.source_port = port_t'($urandom);
    h.dest_port   = dport;
    h.length      = udp_len_t'(8 + nbeats * `BEAT_BYTES);
    h.ttl         = ttl_t'($urandom);
    return h;
  endfunction

  // Called 1 ns after a rising edge, returns at the same phase
  task automatic send_hdr(input udp_hdr_t hdr);
    rx_hdr       = hdr;
    rx_hdr_valid = 1'b1;
    @(negedge clk);
    while (!rx_hdr_ready) @(negedge clk);
    @(posedge clk);
    #1;
    rx_hdr_valid = 1'b0;
  endtask

  task automatic send_beat(input beat_t b);
    rx_beat       = b;
    rx_beat_valid = 1'b1;
    @(negedge clk);
    while (!rx_beat_ready) @(negedge clk);
    @(posedge clk);
    #1;
    rx_beat_valid = 1'b0;
  endtask

  task automatic send_frame(input udp_hdr_t hdr, input int nbeats, input bit looped,
                            output logic [7:0] first_byte);
    beat_t b;
    if (looped) begin
      exp_hdr_q.push_back(expected_reply(hdr));
    end
    send_hdr(hdr);
    for (int i = 0; i < nbeats; i++) begin
      b.data = {$urandom, $urandom};
      b.last = (i == nbeats - 1);
      b.keep = b.last ? (8'hff >> $urandom_range(7)) : 8'hff;
      if (i == 0) begin
        first_byte = b.data[7:0];
      end
      if (looped) begin
        exp_beat_q.push_back(b);
      end
      send_beat(b);
    end
  endtask

  task automatic wait_drain;
    while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    #1;
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test;
    tests_run++;
    if (errors != errors_at_start) begin
      tests_failed++;
      $display("%s: failed with %0d errors", test_name, errors - errors_at_start);
    end else begin
      $display("%s: passed", test_name);
    end
  endtask

  task automatic test_after_reset;
    begin_test("after_reset");
    @(negedge clk);
    if (tx_hdr_valid !== 1'b0) note_failure("tx_hdr_valid is not low after reset");
    if (tx_beat_valid !== 1'b0) note_failure("tx_beat_valid is not low after reset");
    check_led(8'd0, led);
    @(posedge clk);
    #1;
    end_test();
  endtask

  task automatic test_matching;
    logic [7:0] fb;
    begin_test("matching");
    send_frame(make_hdr(`LOOP_UDP_PORT, 5), 5, 1'b1, fb);
    wait_drain();
    end_test();
  endtask

  task automatic test_non_matching;
    logic [7:0] fb;
    int         hdr_before;
    int         beat_before;
    begin_test("non_matching");
    hdr_before  = tx_hdr_count;
    beat_before = tx_beat_count;
    send_frame(make_hdr(port_t'(5000 + $urandom_range(999)), 4), 4, 1'b0, fb);
    repeat (6) @(posedge clk);
    #1;
    if (tx_hdr_count != hdr_before || tx_beat_count != beat_before) begin
      note_failure("dropped datagram produced output on tx");
    end
    send_frame(make_hdr(`LOOP_UDP_PORT, 3), 3, 1'b1, fb);
    wait_drain();
    end_test();
  endtask

  task automatic test_mix;
    logic [7:0] fb;
    bit         looped;
    begin_test("back_to_back_mix");
    stall_en = 1'b1;
    for (int i = 0; i < 12; i++) begin
      looped = (i % 3 != 1);
      send_frame(make_hdr(looped ? `LOOP_UDP_PORT : port_t'(80 + i), i % 6 + 1),
                 i % 6 + 1, looped, fb);
    end
    wait_drain();
    stall_en = 1'b0;
    end_test();
  endtask

  task automatic test_leds;
    logic [7:0] fb;
    begin_test("leds");
    for (int i = 0; i < 3; i++) begin
      send_frame(make_hdr(`LOOP_UDP_PORT, 2), 2, 1'b1, fb);
      wait_drain();
      check_led(fb, led);
    end
    end_test();
  endtask

  initial begin
    void'($urandom(32'h9b834834));
    rst           = 1'b1;
    rx_hdr        = '0;
    rx_hdr_valid  = 1'b0;
    rx_beat       = '0;
    rx_beat_valid = 1'b0;
    tx_hdr_ready  = 1'b1;
    tx_beat_ready = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    test_after_reset();
    test_matching();
    test_non_matching();
    test_mix();
    test_leds();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+.
udp_loopback_pkg.sv
udp_port_filter.sv
udp_reply_header.sv
payload_fifo.sv
led_first_byte.sv
udp_loopback_top.sv
tb_udp_loopback.sv

//--- Makefile
# Verilator build and run of the UDP loopback testbench

SOURCES := $(shell grep -v '^+' build.f) udp_loopback_settings.svh

obj_dir/Vtb_udp_loopback: build.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f build.f --top-module tb_udp_loopback -o Vtb_udp_loopback

run: obj_dir/Vtb_udp_loopback
	./obj_dir/Vtb_udp_loopback | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
